// ==== build.f ====
hdl/perf_pkg.sv
hdl/mem_router.sv
hdl/latency_mem.sv
hdl/miss_timer.sv
hdl/event_counters.sv
hdl/report_fsm.sv
hdl/uart_tx.sv
hdl/mem_perf_top.sv
tests/tb_mem_perf.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_mem_perf
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/tb_mem_perf.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_mem_perf;
	import perf_pkg::*;

	localparam int ACCESS_TIMEOUT = 40;
	localparam int REPORT_TIMEOUT = 2000;

	logic    clk_cpu;
	logic    rst;
	addr_t   rw_address;
	word_t   write_data;
	strobe_t write_strobe;
	logic    read_request;
	logic    write_request;
	word_t   read_data;
	logic    read_response;
	logic    write_response;
	logic    report_start;
	logic    report_busy;
	logic    tx_data;

	word_t        model_mem [MEM_WORDS];
	logic         dir_valid [2][DIR_LINES];
	logic [1:0]   dir_tag [2][DIR_LINES]; // Address bits 8:7
	count_t       model_cnt [NUM_COUNTERS];
	report_byte_t rx_bytes [$];
	logic         rx_active;
	int           rx_ticks;
	report_byte_t rx_shift;

	mem_perf_top mem_perf_top_i (
		.clk_cpu        (clk_cpu),
		.rst            (rst),
		.rw_address     (rw_address),
		.write_data     (write_data),
		.write_strobe   (write_strobe),
		.read_request   (read_request),
		.write_request  (write_request),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.report_start   (report_start),
		.report_busy    (report_busy),
		.tx_data        (tx_data)
	);

	always #50 clk_cpu = ~clk_cpu;

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected)
			stop_with_failure($sformatf("FAILED at %0t ns: %s, got %h, expected %h",
				$time, what, actual, expected));
	endtask

	// Tick 0 is the first falling edge inside the start bit
	always @(negedge clk_cpu) begin
		if (rst) begin
			rx_active = 1'b0;
		end else if (!rx_active) begin
			if (tx_data == 1'b0) begin
				rx_active = 1'b1;
				rx_ticks  = 0;
			end
		end else begin
			rx_ticks++;
			if (rx_ticks % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
				if (rx_ticks / CLKS_PER_BIT == 0) begin
					if (tx_data != 1'b0)
						stop_with_failure("UART start bit did not stay low up to its middle");
				end else if (rx_ticks / CLKS_PER_BIT <= 8) begin
					rx_shift = {tx_data, rx_shift[7:1]}; // LSB arrives first
				end else begin
					if (tx_data != 1'b1)
						stop_with_failure("UART stop bit was missing");
					rx_bytes.push_back(rx_shift);
					rx_active = 1'b0;
				end
			end
		end
	end

	// Updates the model and returns the cycles from request to response
	task automatic model_access(input logic is_write, input addr_t addr, input word_t wdata,
			input strobe_t strb, output int exp_latency);
		int         r;
		int         line;
		logic [1:0] tag;
		logic       hit;
		if (addr > DATA_END) begin
			model_cnt[5] += 16'd1;
			exp_latency = 1;
		end else begin
			r    = (addr <= INSTR_END) ? 0 : 1;
			line = int'(addr[6:4]);
			tag  = addr[8:7];
			hit  = dir_valid[r][line] && (dir_tag[r][line] == tag);
			if (!hit) begin
				dir_valid[r][line] = 1'b1;
				dir_tag[r][line]   = tag;
				model_cnt[r == 0 ? 1 : 4] += 16'd1;
			end
			exp_latency = hit ? 2 : 2 + MISS_PENALTY;
			if (is_write) begin
				model_cnt[3] += 16'd1; // Instruction region writes count here too
				for (int b = 0; b < 4; b++) begin
					if (strb[b])
						model_mem[addr[9:2]][8*b +: 8] = wdata[8*b +: 8];
				end
			end else begin
				model_cnt[r == 0 ? 0 : 2] += 16'd1;
			end
		end
	endtask

	task automatic run_access(input logic is_write, input addr_t addr, input word_t wdata,
			input strobe_t strb, output word_t rdata);
		int   exp_latency;
		int   cycles;
		logic seen;
		model_access(is_write, addr, wdata, strb, exp_latency);
		@(negedge clk_cpu);
		rw_address    = addr;
		write_data    = wdata;
		write_strobe  = strb;
		read_request  = !is_write;
		write_request = is_write;
		cycles = 0;
		seen   = 1'b0;
		rdata  = '0;
		while (!seen && cycles < ACCESS_TIMEOUT) begin
			@(negedge clk_cpu);
			read_request  = 1'b0;
			write_request = 1'b0;
			cycles++;
			seen  = is_write ? write_response : read_response;
			rdata = read_data;
			check_value(is_write ? read_response : write_response, 0,
				"response on the wrong line");
		end
		if (!seen)
			stop_with_failure($sformatf("No bus response for the access at %h within %0d cycles",
				addr, ACCESS_TIMEOUT));
		check_value(cycles, exp_latency, $sformatf("latency of the access at %h", addr));
	endtask

	task automatic read_and_check(input addr_t addr);
		word_t rdata;
		word_t expected;
		expected = (addr > DATA_END) ? '0 : model_mem[addr[9:2]];
		run_access(1'b0, addr, '0, '0, rdata);
		check_value(rdata, expected, $sformatf("read data at %h", addr));
	endtask

	task automatic write_word(input addr_t addr, input word_t data, input strobe_t strb);
		word_t ignored_data;
		run_access(1'b1, addr, data, strb, ignored_data);
	endtask

	function automatic addr_t mapped_addr();
		return addr_t'(($urandom % MEM_WORDS) * 4);
	endfunction

	function automatic addr_t unmapped_addr();
		return ($urandom & 32'hFFFF_FFFC) | 32'h0000_0400;
	endfunction

	task automatic random_traffic(input int count);
		int kind;
		for (int i = 0; i < count; i++) begin
			kind = $urandom % 8;
			if (kind < 3)
				write_word(mapped_addr(), $urandom, 4'hF);
			else if (kind == 3)
				write_word(mapped_addr(), $urandom, strobe_t'($urandom));
			else if (kind < 7)
				read_and_check(mapped_addr());
			else if ($urandom % 2 == 0)
				read_and_check(unmapped_addr());
			else
				write_word(unmapped_addr(), $urandom, 4'hF);
		end
	endtask

	task automatic run_report(input logic extra_start, input int traffic_during);
		count_t snap [NUM_COUNTERS];
		int     cycles;
		snap = model_cnt;
		rx_bytes.delete();
		@(negedge clk_cpu);
		report_start = 1'b1;
		@(negedge clk_cpu);
		report_start = 1'b0;
		check_value(report_busy, 1, "report_busy one cycle after report_start");
		if (extra_start) begin
			repeat (3) @(negedge clk_cpu);
			report_start = 1'b1;
			@(negedge clk_cpu);
			report_start = 1'b0;
		end
		random_traffic(traffic_during);
		cycles = 0;
		while (report_busy && cycles < REPORT_TIMEOUT) begin
			@(negedge clk_cpu);
			cycles++;
		end
		if (report_busy)
			stop_with_failure("report_busy did not fall before the report timeout");
		check_value(rx_bytes.size(), REPORT_BYTES, "number of report bytes");
		for (int i = 0; i < REPORT_BYTES; i++)
			check_value(rx_bytes[i], (i % 2 == 0) ? snap[i / 2][7:0] : snap[i / 2][15:8],
				$sformatf("report byte %0d", i));
		repeat (12 * CLKS_PER_BIT) begin // Longer than one UART frame
			@(negedge clk_cpu);
			check_value(report_busy, 0, "report_busy after the report ended");
		end
		check_value(rx_bytes.size(), REPORT_BYTES, "bytes received after the report ended");
	endtask

	initial begin
		addr_t addr;
		clk_cpu       = 1'b0;
		rst           = 1'b1;
		rw_address    = '0;
		write_data    = '0;
		write_strobe  = '0;
		read_request  = 1'b0;
		write_request = 1'b0;
		report_start  = 1'b0;
		void'($urandom(32'he30f));
		for (int i = 0; i < MEM_WORDS; i++)
			model_mem[i] = '0;
		for (int i = 0; i < DIR_LINES; i++) begin
			dir_valid[0][i] = 1'b0;
			dir_valid[1][i] = 1'b0;
		end
		for (int i = 0; i < NUM_COUNTERS; i++)
			model_cnt[i] = '0;
		repeat (3) @(negedge clk_cpu);
		rst = 1'b0;
		repeat (300) @(negedge clk_cpu); // Memory clear runs after reset

		for (int i = 0; i < 40; i++) begin
			addr = mapped_addr();
			write_word(addr, $urandom, 4'hF);
			read_and_check(addr);
			read_and_check(mapped_addr());
		end
		for (int i = 0; i < 30; i++) begin
			addr = mapped_addr();
			write_word(addr, $urandom, 4'hF);
			write_word(addr, $urandom, strobe_t'($urandom));
			read_and_check(addr);
		end
		for (int i = 0; i < 20; i++) begin
			addr = unmapped_addr();
			write_word(addr & 32'h3FC, $urandom, 4'hF);
			write_word(addr, $urandom, 4'hF);
			read_and_check(addr);
			read_and_check(addr & 32'h3FC); // Alias in mapped space keeps its old word
		end

		random_traffic(80);
		run_report(1'b0, 0);
		random_traffic(60);
		run_report(1'b1, 0);
		random_traffic(20);
		run_report(1'b0, 12);
		read_and_check(mapped_addr());

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hdl/mem_perf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_perf_top (
	input  logic             clk_cpu,
	input  logic             rst,
	input  perf_pkg::addr_t   rw_address,
	input  perf_pkg::word_t   write_data,
	input  perf_pkg::strobe_t write_strobe,
	input  logic             read_request,
	input  logic             write_request,
	output perf_pkg::word_t   read_data,
	output logic             read_response,
	output logic             write_response,
	input  logic             report_start,
	output logic             report_busy,
	output logic             tx_data
);
	import perf_pkg::*;

	logic         acc_valid;
	logic         acc_write;
	region_t      acc_region;
	addr_t        acc_addr;
	word_t        acc_wdata;
	strobe_t      acc_strobe;
	logic         acc_done;
	word_t        acc_rdata;
	logic         miss_start;
	logic         penalty_done;
	logic         ev_instr_read;
	logic         ev_instr_miss;
	logic         ev_data_read;
	logic         ev_data_write;
	logic         ev_data_miss;
	logic         ev_unmapped;
	logic         snapshot;
	logic [3:0]   byte_sel;
	report_byte_t report_byte;
	logic         tx_push;
	report_byte_t tx_byte;
	logic         tx_credit;
	logic         tx_idle;

	mem_router mem_router_i (
		.clk_cpu        (clk_cpu),
		.rst            (rst),
		.rw_address     (rw_address),
		.write_data     (write_data),
		.write_strobe   (write_strobe),
		.read_request   (read_request),
		.write_request  (write_request),
		.read_data      (read_data),
		.read_response  (read_response),
		.write_response (write_response),
		.acc_valid      (acc_valid),
		.acc_write      (acc_write),
		.acc_region     (acc_region),
		.acc_addr       (acc_addr),
		.acc_wdata      (acc_wdata),
		.acc_strobe     (acc_strobe),
		.acc_done       (acc_done),
		.acc_rdata      (acc_rdata),
		.ev_instr_read  (ev_instr_read),
		.ev_data_read   (ev_data_read),
		.ev_data_write  (ev_data_write),
		.ev_unmapped    (ev_unmapped)
	);

	latency_mem latency_mem_i (
		.clk_cpu       (clk_cpu),
		.rst           (rst),
		.acc_valid     (acc_valid),
		.acc_write     (acc_write),
		.acc_region    (acc_region),
		.acc_addr      (acc_addr),
		.acc_wdata     (acc_wdata),
		.acc_strobe    (acc_strobe),
		.acc_done      (acc_done),
		.acc_rdata     (acc_rdata),
		.miss_start    (miss_start),
		.penalty_done  (penalty_done),
		.ev_instr_miss (ev_instr_miss),
		.ev_data_miss  (ev_data_miss)
	);

	miss_timer miss_timer_i (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.miss_start   (miss_start),
		.penalty_done (penalty_done)
	);

	event_counters event_counters_i (
		.clk_cpu       (clk_cpu),
		.rst           (rst),
		.ev_instr_read (ev_instr_read),
		.ev_instr_miss (ev_instr_miss),
		.ev_data_read  (ev_data_read),
		.ev_data_write (ev_data_write),
		.ev_data_miss  (ev_data_miss),
		.ev_unmapped   (ev_unmapped),
		.snapshot      (snapshot),
		.byte_sel      (byte_sel),
		.report_byte   (report_byte)
	);

	report_fsm report_fsm_i (
		.clk_cpu      (clk_cpu),
		.rst          (rst),
		.report_start (report_start),
		.report_busy  (report_busy),
		.snapshot     (snapshot),
		.byte_sel     (byte_sel),
		.report_byte  (report_byte),
		.tx_push      (tx_push),
		.tx_byte      (tx_byte),
		.tx_credit    (tx_credit),
		.tx_idle      (tx_idle)
	);

	uart_tx uart_tx_i (
		.clk_cpu   (clk_cpu),
		.rst       (rst),
		.tx_push   (tx_push),
		.tx_byte   (tx_byte),
		.tx_credit (tx_credit),
		.tx_idle   (tx_idle),
		.tx_data   (tx_data)
	);

endmodule

`default_nettype wire

// ==== hdl/uart_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module uart_tx (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  tx_push,
	input  perf_pkg::report_byte_t tx_byte,
	output logic                  tx_credit,
	output logic                  tx_idle,
	output logic                  tx_data
);
	import perf_pkg::*;

	typedef logic [$clog2(CLKS_PER_BIT)-1:0] bit_clk_t;
	typedef enum logic {tx_stopped, tx_shifting} tx_state_t;

	tx_state_t    state;
	report_byte_t queue [2];
	logic         wr_ptr;
	logic         rd_ptr;
	logic [1:0]   fill;
	logic         pop;
	logic [8:0]   shreg;
	logic [3:0]   bits_left;
	bit_clk_t     clk_cnt;

	assign pop     = (state == tx_stopped) && (fill != '0);
	assign tx_idle = (state == tx_stopped) && (fill == '0);

	always_ff @(posedge clk_cpu) begin
		if (tx_push)
			queue[wr_ptr] <= tx_byte;
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state     <= tx_stopped;
			wr_ptr    <= 1'b0;
			rd_ptr    <= 1'b0;
			fill      <= '0;
			tx_credit <= 1'b0;
			tx_data   <= 1'b1;
		end else begin
			tx_credit <= pop;
			fill      <= fill + 2'(tx_push) - 2'(pop);
			if (tx_push)
				wr_ptr <= !wr_ptr;
			if (pop) begin
				rd_ptr    <= !rd_ptr;
				shreg     <= {1'b1, queue[rd_ptr]}; // Stop bit rides above the data
				bits_left <= 4'd9;
				clk_cnt   <= bit_clk_t'(CLKS_PER_BIT - 1);
				tx_data   <= 1'b0;
				state     <= tx_shifting;
			end else if (state == tx_shifting) begin
				if (clk_cnt != '0) begin
					clk_cnt <= clk_cnt - 1'b1;
				end else if (bits_left != '0) begin
					tx_data   <= shreg[0];
					shreg     <= {1'b1, shreg[8:1]};
					bits_left <= bits_left - 1'b1;
					clk_cnt   <= bit_clk_t'(CLKS_PER_BIT - 1);
				end else begin
					state <= tx_stopped; // Stop bit has had its full time
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/report_fsm.sv ====
`timescale 1ns/100ps
`default_nettype none

module report_fsm (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  report_start,
	output logic                  report_busy,
	output logic                  snapshot,
	output logic [3:0]            byte_sel,
	input  perf_pkg::report_byte_t report_byte,
	output logic                  tx_push,
	output perf_pkg::report_byte_t tx_byte,
	input  logic                  tx_credit,
	input  logic                  tx_idle
);
	import perf_pkg::*;

	typedef enum logic [1:0] {st_idle, st_capture, st_send, st_drain} report_state_t;

	report_state_t state;
	credit_t       credits;
	logic [3:0]    byte_idx;
	logic          push_now;

	assign push_now    = (state == st_send) && (credits != '0);
	assign report_busy = (state != st_idle);
	assign snapshot    = (state == st_capture);
	assign byte_sel    = byte_idx;

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state    <= st_idle;
			credits  <= credit_t'(TX_CREDITS);
			byte_idx <= '0;
			tx_push  <= 1'b0;
		end else begin
			tx_push <= push_now;
			credits <= credits - credit_t'(push_now) + credit_t'(tx_credit);
			case (state)
				st_idle: begin
					if (report_start)
						state <= st_capture;
				end
				st_capture: begin
					byte_idx <= '0;
					state    <= st_send;
				end
				st_send: begin
					if (push_now) begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 4'(REPORT_BYTES - 1))
							state <= st_drain;
					end
				end
				st_drain: begin
					if (!tx_push && tx_idle) // The last push may still be on its way
						state <= st_idle;
				end
				default: state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (push_now)
			tx_byte <= report_byte;
	end

endmodule

`default_nettype wire

// ==== hdl/event_counters.sv ====
`timescale 1ns/100ps
`default_nettype none

module event_counters (
	input  logic                  clk_cpu,
	input  logic                  rst,
	input  logic                  ev_instr_read,
	input  logic                  ev_instr_miss,
	input  logic                  ev_data_read,
	input  logic                  ev_data_write,
	input  logic                  ev_data_miss,
	input  logic                  ev_unmapped,
	input  logic                  snapshot,
	input  logic [3:0]            byte_sel,
	output perf_pkg::report_byte_t report_byte
);
	import perf_pkg::*;

	logic [NUM_COUNTERS-1:0] ev;
	count_t                  cnt [NUM_COUNTERS];
	count_t                  hold [NUM_COUNTERS];
	logic [2:0]              hold_idx;

	assign ev = {ev_unmapped, ev_data_miss, ev_data_write,
		ev_data_read, ev_instr_miss, ev_instr_read}; // Bit 0 is first in the report

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			for (int i = 0; i < NUM_COUNTERS; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < NUM_COUNTERS; i++) begin
				if (ev[i] && cnt[i] != '1)
					cnt[i] <= cnt[i] + 1'b1; // Sticks at full scale
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (snapshot)
			hold <= cnt;
	end

	assign hold_idx = byte_sel[3:1];

	always_comb begin
		if (hold_idx < 3'(NUM_COUNTERS))
			report_byte = byte_sel[0] ? hold[hold_idx][15:8] : hold[hold_idx][7:0];
		else
			report_byte = '0;
	end

endmodule

`default_nettype wire

// ==== hdl/miss_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module miss_timer (
	input  logic clk_cpu,
	input  logic rst,
	input  logic miss_start,
	output logic penalty_done
);
	import perf_pkg::*;

	typedef logic [$clog2(MISS_PENALTY)-1:0] penalty_cnt_t;

	penalty_cnt_t remaining;

	// miss_start and the registered acc_done each take one cycle of the penalty
	always_ff @(posedge clk_cpu) begin
		if (rst)
			remaining <= '0;
		else if (miss_start)
			remaining <= penalty_cnt_t'(MISS_PENALTY - 1);
		else if (remaining != '0)
			remaining <= remaining - 1'b1;
	end

	assign penalty_done = (remaining == penalty_cnt_t'(1));

endmodule

`default_nettype wire

// ==== hdl/latency_mem.sv ====
`timescale 1ns/100ps
`default_nettype none

module latency_mem (
	input  logic             clk_cpu,
	input  logic             rst,
	input  logic             acc_valid,
	input  logic             acc_write,
	input  perf_pkg::region_t acc_region,
	input  perf_pkg::addr_t   acc_addr,
	input  perf_pkg::word_t   acc_wdata,
	input  perf_pkg::strobe_t acc_strobe,
	output logic             acc_done,
	output perf_pkg::word_t   acc_rdata,
	output logic             miss_start,
	input  logic             penalty_done,
	output logic             ev_instr_miss,
	output logic             ev_data_miss
);
	import perf_pkg::*;

	typedef logic [$clog2(MEM_WORDS)-1:0] word_idx_t;
	typedef logic [$clog2(DIR_LINES)-1:0] line_idx_t;
	typedef logic [$clog2(INSTR_END + 1) - $clog2(LINE_WORDS * DIR_LINES) - 3:0] tag_t;
	typedef enum logic [1:0] {st_clear, st_ready, st_penalty} mem_state_t;

	mem_state_t state;
	word_t      mem [MEM_WORDS];
	word_idx_t  clear_idx;
	word_idx_t  word_idx;
	line_idx_t  line_idx;
	tag_t       line_tag;
	logic       dir_sel;
	logic       hit;
	logic [DIR_LINES-1:0] dir_valid [2];
	tag_t       dir_tag [2][DIR_LINES];

	// Same offsets in both regions, so the region bit itself is not part of the tag
	assign word_idx = acc_addr[$clog2(MEM_WORDS)+1:2];
	assign line_idx = acc_addr[$clog2(LINE_WORDS)+2 +: $clog2(DIR_LINES)];
	assign line_tag = acc_addr[$clog2(LINE_WORDS * DIR_LINES)+2 +: $bits(tag_t)];
	assign dir_sel  = (acc_region == region_data);
	assign hit      = dir_valid[dir_sel][line_idx] && (dir_tag[dir_sel][line_idx] == line_tag);

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			state         <= st_clear;
			clear_idx     <= '0;
			acc_done      <= 1'b0;
			miss_start    <= 1'b0;
			ev_instr_miss <= 1'b0;
			ev_data_miss  <= 1'b0;
			dir_valid[0]  <= '0;
			dir_valid[1]  <= '0;
		end else begin
			acc_done      <= 1'b0;
			miss_start    <= 1'b0;
			ev_instr_miss <= 1'b0;
			ev_data_miss  <= 1'b0;
			case (state)
				st_clear: begin
					clear_idx <= clear_idx + 1'b1;
					if (clear_idx == word_idx_t'(MEM_WORDS - 1))
						state <= st_ready;
				end
				st_ready: begin
					if (acc_valid && hit) begin
						acc_done <= 1'b1;
					end else if (acc_valid) begin
						dir_valid[dir_sel][line_idx] <= 1'b1; // Writes allocate like reads
						miss_start    <= 1'b1;
						ev_instr_miss <= !dir_sel;
						ev_data_miss  <= dir_sel;
						state         <= st_penalty;
					end
				end
				st_penalty: begin
					if (penalty_done) begin
						acc_done <= 1'b1;
						state    <= st_ready;
					end
				end
				default: state <= st_ready;
			endcase
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (state == st_ready && acc_valid && !hit)
			dir_tag[dir_sel][line_idx] <= line_tag;
	end

	always_ff @(posedge clk_cpu) begin
		if (state == st_clear) begin
			mem[clear_idx] <= '0;
		end else if (state == st_ready && acc_valid && acc_write) begin
			for (int i = 0; i < $bits(strobe_t); i++) begin
				if (acc_strobe[i])
					mem[word_idx][8*i +: 8] <= acc_wdata[8*i +: 8];
			end
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (state == st_ready && acc_valid)
			acc_rdata <= mem[word_idx]; // Held until acc_done, even through a miss
	end

endmodule

`default_nettype wire

// ==== hdl/mem_router.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_router (
	input  logic             clk_cpu,
	input  logic             rst,
	input  perf_pkg::addr_t   rw_address,
	input  perf_pkg::word_t   write_data,
	input  perf_pkg::strobe_t write_strobe,
	input  logic             read_request,
	input  logic             write_request,
	output perf_pkg::word_t   read_data,
	output logic             read_response,
	output logic             write_response,
	output logic             acc_valid,
	output logic             acc_write,
	output perf_pkg::region_t acc_region,
	output perf_pkg::addr_t   acc_addr,
	output perf_pkg::word_t   acc_wdata,
	output perf_pkg::strobe_t acc_strobe,
	input  logic             acc_done,
	input  perf_pkg::word_t   acc_rdata,
	output logic             ev_instr_read,
	output logic             ev_data_read,
	output logic             ev_data_write,
	output logic             ev_unmapped
);
	import perf_pkg::*;

	region_t req_region;
	logic    req_any;
	logic    unmapped_rd_rsp;
	logic    unmapped_wr_rsp;

	assign req_any = read_request || write_request;

	always_comb begin
		if (rw_address <= INSTR_END)
			req_region = region_instr;
		else if (rw_address <= DATA_END)
			req_region = region_data;
		else
			req_region = region_unmapped;
	end

	always_ff @(posedge clk_cpu) begin
		if (rst) begin
			acc_valid       <= 1'b0;
			acc_write       <= 1'b0;
			unmapped_rd_rsp <= 1'b0;
			unmapped_wr_rsp <= 1'b0;
			ev_instr_read   <= 1'b0;
			ev_data_read    <= 1'b0;
			ev_data_write   <= 1'b0;
			ev_unmapped     <= 1'b0;
		end else begin
			acc_valid       <= req_any && (req_region != region_unmapped);
			unmapped_rd_rsp <= read_request && (req_region == region_unmapped);
			unmapped_wr_rsp <= write_request && (req_region == region_unmapped);
			ev_instr_read   <= read_request && (req_region == region_instr);
			ev_data_read    <= read_request && (req_region == region_data);
			// Instruction region writes count as data writes too
			ev_data_write   <= write_request && (req_region != region_unmapped);
			ev_unmapped     <= req_any && (req_region == region_unmapped);
			if (req_any)
				acc_write <= write_request; // Direction steers the later response
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (req_any) begin
			acc_region <= req_region;
			acc_addr   <= rw_address;
			acc_wdata  <= write_data;
			acc_strobe <= write_strobe;
		end
	end

	assign read_response  = (acc_done && !acc_write) || unmapped_rd_rsp;
	assign write_response = (acc_done && acc_write) || unmapped_wr_rsp;
	assign read_data      = (acc_done && !acc_write) ? acc_rdata : '0; // Unmapped reads see zero

endmodule

`default_nettype wire

// ==== hdl/perf_pkg.sv ====
`default_nettype none

package perf_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [3:0]  strobe_t;
	typedef logic [15:0] count_t;
	typedef logic [7:0]  report_byte_t;
	typedef logic [1:0]  credit_t;

	typedef enum logic [1:0] {
		region_instr,
		region_data,
		region_unmapped
	} region_t;

	localparam addr_t INSTR_END  = 32'h1FF;
	localparam addr_t DATA_END   = 32'h3FF;
	localparam int    MEM_WORDS  = 256;
	localparam int    LINE_WORDS = 4;
	localparam int    DIR_LINES  = 8;

	localparam int MISS_PENALTY = 6;
	localparam int CLKS_PER_BIT = 4;
	localparam int TX_CREDITS   = 2;

	// Report order is instr rd, instr miss, data rd, data wr, data miss and unmapped
	localparam int NUM_COUNTERS = 6;
	localparam int REPORT_BYTES = 12;

endpackage

`default_nettype wire
